//--- Makefile
TOP = tb_flash_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --top-module flash_ctrl_top source/flash_pkg.sv \
		source/flash_cfg_regs.sv source/flash_read_engine.sv source/flash_ctrl_top.sv

clean:
	rm -rf obj_dir

//--- list.f
source/flash_pkg.sv
source/flash_cfg_regs.sv
source/flash_read_engine.sv
source/flash_ctrl_top.sv
tests/flash_model.sv
tests/tb_flash_ctrl.sv

//--- source/flash_cfg_regs.sv
`timescale 1ns/1ps

module flash_cfg_regs import flash_pkg::*; #(
  parameter int rst_dly        = def_rst_dly,         // cycles per byte after reset
  parameter int rst_big_endian = def_rst_big_endian   // byte order after reset
) (
  input  logic             clk,
  input  logic             rst,
  // write port
  input  logic             cfg_we,          // one cycle strobe
  input  logic [dly_w-1:0] cfg_dly,
  input  logic             cfg_big_endian,
  // to read engine
  output logic [dly_w-1:0] acc_dly,
  output logic             big_endian
);

  ////////////////////
  // reset values
  ////////////////////

  // never less than one cycle per byte
  localparam logic [dly_w-1:0] dly_init = (rst_dly < 1) ? dly_w'(1) : dly_w'(rst_dly);
  localparam logic             be_init  = (rst_big_endian != 0);

  ////////////////////
  // write data
  ////////////////////

  logic [dly_w-1:0] dly_wr;  // delay as it gets stored

  // zero would leave the engine without a sample cycle, so it becomes 1
  assign dly_wr = (cfg_dly == '0) ? dly_w'(1) : cfg_dly;

  ////////////////////
  // registers
  ////////////////////

  // access delay
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_dly <= dly_init;
    end else if (cfg_we) begin
      acc_dly <= dly_wr;
    end
  end

  // byte order, 1 puts the lowest flash address in bits 31:24
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      big_endian <= be_init;
    end else if (cfg_we) begin
      big_endian <= cfg_big_endian;
    end
  end

  // both values are picked up by the engine only when it takes a request,
  // so a rewrite in the middle of a read has no effect on that read

endmodule

//--- source/flash_ctrl_top.sv
`timescale 1ns/1ps

module flash_ctrl_top import flash_pkg::*; #(
  parameter int faw            = def_faw,
  parameter int qaw            = def_qaw,
  parameter int rst_dly        = def_rst_dly,         // must be 1 or more
  parameter int rst_big_endian = def_rst_big_endian
) (
  input  logic                clk,
  input  logic                rst,
  // memory bus
  input  logic                cs,
  input  logic                we,
  input  logic [qaw-1:0]      adr,
  input  logic [3:0]          sel,
  input  logic [bus_dw-1:0]   dat_w,
  output logic [bus_dw-1:0]   dat_r,
  output logic                ack,
  output logic                err,
  // configuration write
  input  logic                cfg_we,
  input  logic [dly_w-1:0]    cfg_dly,
  input  logic                cfg_big_endian,
  // flash pins
  output logic [faw-1:0]      fl_adr,
  output logic                fl_ce_n,
  output logic                fl_oe_n,
  output logic                fl_we_n,
  output logic                fl_rst_n,
  input  logic [flash_dw-1:0] fl_dat_r
);

  logic [dly_w-1:0] acc_dly;     // cycles per flash byte
  logic             big_endian;

  ////////////////////
  // config beside the engine
  ////////////////////

  flash_cfg_regs #(
    .rst_dly        (rst_dly),
    .rst_big_endian (rst_big_endian)
  ) cfg0 (
    .clk            (clk),
    .rst            (rst),
    .cfg_we         (cfg_we),
    .cfg_dly        (cfg_dly),
    .cfg_big_endian (cfg_big_endian),
    .acc_dly        (acc_dly),
    .big_endian     (big_endian)
  );

  // no extra stages, bus timing is the engine's own
  flash_read_engine #(
    .faw        (faw),
    .qaw        (qaw)
  ) eng0 (
    .clk        (clk),
    .rst        (rst),
    .cs         (cs),
    .we         (we),
    .adr        (adr),
    .sel        (sel),
    .dat_w      (dat_w),
    .dat_r      (dat_r),
    .ack        (ack),
    .err        (err),
    .acc_dly    (acc_dly),
    .big_endian (big_endian),
    .fl_adr     (fl_adr),
    .fl_ce_n    (fl_ce_n),
    .fl_oe_n    (fl_oe_n),
    .fl_we_n    (fl_we_n),
    .fl_rst_n   (fl_rst_n),
    .fl_dat_r   (fl_dat_r)
  );

endmodule

//--- source/flash_pkg.sv
package flash_pkg;

  ////////////////////
  // bus and flash widths
  ////////////////////

  localparam int bus_dw   = 32;  // memory bus data
  localparam int flash_dw = 8;   // parallel nor flash data

  // flash reads per bus word
  localparam int bytes_per_word = bus_dw / flash_dw;
  localparam int byte_idx_w     = $clog2(bytes_per_word);  // byte lane index bits

  // access delay field, cycles per flash byte
  localparam int dly_w = 4;

  ////////////////////
  // defaults for the top level parameters
  ////////////////////

  localparam int def_faw = 22;  // flash address bits, 4MB part
  localparam int def_qaw = 22;  // bus address bits

  // 4 clocks covers a 70ns part at 50MHz
  localparam int def_rst_dly = 4;

  localparam int def_rst_big_endian = 1;  // 1 big endian, 0 little endian

endpackage

//--- source/flash_read_engine.sv
`timescale 1ns/1ps

module flash_read_engine import flash_pkg::*; #(
  parameter int faw = def_faw,  // flash address width
  parameter int qaw = def_qaw   // bus address width
) (
  input  logic                clk,
  input  logic                rst,
  // memory bus
  input  logic                cs,
  input  logic                we,
  input  logic [qaw-1:0]      adr,
  input  logic [3:0]          sel,     // ignored since reads are full word
  input  logic [bus_dw-1:0]   dat_w,   // no writes to flash
  output logic [bus_dw-1:0]   dat_r,
  output logic                ack,
  output logic                err,
  // configuration
  input  logic [dly_w-1:0]    acc_dly,
  input  logic                big_endian,
  // flash pins
  output logic [faw-1:0]      fl_adr,
  output logic                fl_ce_n,
  output logic                fl_oe_n,
  output logic                fl_we_n,
  output logic                fl_rst_n,
  input  logic [flash_dw-1:0] fl_dat_r
);

  localparam int wa_w = faw - byte_idx_w;  // word part of the flash address
  localparam logic [byte_idx_w-1:0] last_idx = byte_idx_w'(bytes_per_word - 1);

  ////////////////////
  // flash pin state
  ////////////////////

  // held in reset then chip enabled with outputs on for good
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fl_ce_n  <= 1'b1;
      fl_oe_n  <= 1'b1;
      fl_we_n  <= 1'b1;
      fl_rst_n <= 1'b0;  // flash reset asserted
    end else begin
      fl_ce_n  <= 1'b0;
      fl_oe_n  <= 1'b0;
      fl_we_n  <= 1'b1;  // never programmed from here
      fl_rst_n <= 1'b1;
    end
  end

  ////////////////////
  // cs edge detect
  ////////////////////

  logic cs_d;
  logic cs_pos;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cs_d <= 1'b0;
    end else begin
      cs_d <= cs;
    end
  end

  assign cs_pos = cs & ~cs_d;  // master holds a new request until ack or err

  ////////////////////
  // byte sequencer
  ////////////////////

  logic                  busy;     // read in progress
  logic [byte_idx_w-1:0] cnt;      // byte index on the flash now
  logic [byte_idx_w-1:0] cnt_nxt;
  logic [dly_w-1:0]      timer;    // cycles left on this byte
  logic [dly_w-1:0]      dly_q;    // delay latched for this request
  logic                  be_q;     // byte order latched for this request
  logic                  sample;   // last cycle of a byte with data valid
  logic [byte_idx_w-1:0] lane;     // where the sampled byte goes in the word

  assign cnt_nxt = cnt + 1'b1;
  assign sample  = busy & (timer == '0);
  assign lane    = be_q ? (last_idx - cnt) : cnt;  // big endian mirrors the index

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy   <= 1'b0;
      cnt    <= '0;
      timer  <= '0;
      dly_q  <= '0;
      be_q   <= 1'b0;
      fl_adr <= '0;
      ack    <= 1'b0;
      err    <= 1'b0;
    end else begin
      ack <= 1'b0;  // both are single cycle pulses
      err <= 1'b0;
      if (!busy) begin
        if (cs_pos && we) begin
          err <= 1'b1;  // writes rejected with fl_adr left alone
        end else if (cs_pos) begin
          busy   <= 1'b1;
          cnt    <= '0;
          timer  <= acc_dly - dly_w'(1);
          dly_q  <= acc_dly;
          be_q   <= big_endian;
          fl_adr <= {wa_w'(adr[qaw-1:byte_idx_w]), byte_idx_w'(0)};  // byte 0 of word
        end
      end else if (!sample) begin
        timer <= timer - dly_w'(1);  // byte still settling
      end else if (cnt == last_idx) begin
        busy <= 1'b0;
        ack  <= 1'b1;  // last byte lands in dat_r on this same edge
      end else begin
        cnt    <= cnt_nxt;
        timer  <= dly_q - dly_w'(1);
        fl_adr <= {fl_adr[faw-1:byte_idx_w], cnt_nxt};  // step to next byte
      end
    end
  end

  ////////////////////
  // word assembly
  ////////////////////

  logic [bus_dw-1:0] asm_q;    // word being assembled
  logic [bus_dw-1:0] asm_nxt;  // assembly word with the sampled byte merged

  // each byte written straight into its lane without shifting
  always_comb begin
    asm_nxt = asm_q;
    asm_nxt[lane*flash_dw +: flash_dw] = fl_dat_r;
  end

  // dat_r holds the last word until the next read completes
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      asm_q <= '0;
      dat_r <= '0;
    end else if (sample) begin
      asm_q <= asm_nxt;
      if (cnt == last_idx) begin
        dat_r <= asm_nxt;  // whole word appears together with ack
      end
    end
  end

endmodule

//--- tests/flash_model.sv
`timescale 1ns/1ps

module flash_model import flash_pkg::*; #(
  parameter int faw           = def_faw,  // address pins
  parameter int access_cycles = 4         // clocks from address change to valid data
) (
  input  logic                clk,
  input  logic                fl_rst_n,
  input  logic [faw-1:0]      fl_adr,
  input  logic                fl_ce_n,
  input  logic                fl_oe_n,
  output logic [flash_dw-1:0] fl_dat_r
);

  ////////////////////
  // address stability
  ////////////////////

  logic [faw-1:0] adr_q;  // address seen at the last edge
  int             held;   // full cycles that address has been stable
  logic           valid;

  always_ff @(posedge clk or negedge fl_rst_n) begin
    if (!fl_rst_n) begin
      adr_q <= '0;
      held  <= 0;
    end else if (fl_adr != adr_q) begin
      adr_q <= fl_adr;
      held  <= 1;  // one cycle already passed since the change
    end else if (held < access_cycles) begin
      held <= held + 1;  // saturates, only the threshold matters
    end
  end

  // the coming edge closes one more stable cycle, hence held + 1
  assign valid = !fl_ce_n && !fl_oe_n && (fl_adr == adr_q) &&
                 (held + 1 >= access_cycles);

  ////////////////////
  // data rule
  ////////////////////

  // array contents are a fixed function of the address
  assign fl_dat_r = valid ? (fl_adr[7:0] ^ 8'ha5) : 8'hee;  // ee while not settled

endmodule

//--- tests/tb_flash_ctrl.sv
`timescale 1ns/1ps

module tb_flash_ctrl import flash_pkg::*; ();

  localparam int faw     = def_faw;
  localparam int qaw     = def_qaw;
  localparam int timeout = 200;  // cycles per wait

  logic                clk;
  logic                rst;
  logic                cs;
  logic                we;
  logic [qaw-1:0]      adr;
  logic [3:0]          sel;
  logic [bus_dw-1:0]   dat_w;
  logic [bus_dw-1:0]   dat_r;
  logic                ack;
  logic                err;
  logic                cfg_we;
  logic [dly_w-1:0]    cfg_dly;
  logic                cfg_big_endian;
  logic [faw-1:0]      fl_adr;
  logic                fl_ce_n;
  logic                fl_oe_n;
  logic                fl_we_n;
  logic                fl_rst_n;
  logic [flash_dw-1:0] fl_dat_r;

  int             errors;
  int             seed;
  logic [qaw-1:0] addrs [20];  // reused for both byte orders
  logic           out_of_reset;

  flash_ctrl_top dut0 (
    .clk(clk), .rst(rst), .cs(cs), .we(we), .adr(adr), .sel(sel), .dat_w(dat_w),
    .dat_r(dat_r), .ack(ack), .err(err), .cfg_we(cfg_we), .cfg_dly(cfg_dly),
    .cfg_big_endian(cfg_big_endian), .fl_adr(fl_adr), .fl_ce_n(fl_ce_n),
    .fl_oe_n(fl_oe_n), .fl_we_n(fl_we_n), .fl_rst_n(fl_rst_n), .fl_dat_r(fl_dat_r)
  );

  flash_model #(.faw(faw), .access_cycles(4)) flash0 (
    .clk(clk), .fl_rst_n(fl_rst_n), .fl_adr(fl_adr), .fl_ce_n(fl_ce_n),
    .fl_oe_n(fl_oe_n), .fl_dat_r(fl_dat_r)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  ////////////////////
  // checkers
  ////////////////////

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s expected %h got %h", name, exp, got);
    end
  endtask

  // ack and err are one cycle pulses
  ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else begin
      errors++;
      $display("ack stayed high for more than one cycle");
    end
  err_pulse: assert property (@(posedge clk) disable iff (rst) err |=> !err)
    else begin
      errors++;
      $display("err stayed high for more than one cycle");
    end
  // quiet bus while no request is open
  no_stray: assert property (@(posedge clk) disable iff (rst) (ack || err) |-> cs)
    else begin
      errors++;
      $display("ack or err without an open request");
    end
  // dat_r only moves when a read completes
  dat_hold: assert property (@(posedge clk) disable iff (rst) !$stable(dat_r) |-> ack)
    else begin
      errors++;
      $display("dat_r changed before the read completed");
    end

  always @(posedge clk or posedge rst) begin
    if (rst) out_of_reset <= 1'b0;
    else     out_of_reset <= 1'b1;  // set at the first clock after reset
  end

  // flash pins in reset then in permanent read mode
  always @(negedge clk) begin
    if (rst) begin
      check_eq("fl_ce_n", 1, 32'(fl_ce_n));
      check_eq("fl_oe_n", 1, 32'(fl_oe_n));
      check_eq("fl_we_n", 1, 32'(fl_we_n));
      check_eq("fl_rst_n", 0, 32'(fl_rst_n));
    end else if (out_of_reset) begin
      check_eq("fl_ce_n", 0, 32'(fl_ce_n));
      check_eq("fl_oe_n", 0, 32'(fl_oe_n));
      check_eq("fl_we_n", 1, 32'(fl_we_n));
      check_eq("fl_rst_n", 1, 32'(fl_rst_n));
    end
  end

  ////////////////////
  // expected word from bytes of adr xor a5
  function automatic logic [31:0] model_word(input logic [qaw-1:0] a, input logic big);
    logic [7:0] b [4];
    for (int k = 0; k < 4; k++) b[k] = {a[7:2], 2'(k)} ^ 8'ha5;
    return big ? {b[0], b[1], b[2], b[3]} : {b[3], b[2], b[1], b[0]};
  endfunction

  ////////////////////
  // bus tasks
  ////////////////////

  // n counts edges after the one that raised cs
  task automatic wait_response(output int n);
    n = 0;
    @(negedge clk);
    while (!ack && !err && n < timeout) begin
      @(negedge clk);
      n++;
    end
  endtask

  task automatic write_config(input int dly, input logic big);
    @(posedge clk);
    cfg_we         <= 1'b1;
    cfg_dly        <= dly_w'(dly);
    cfg_big_endian <= big;
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  task automatic read_word(input logic [qaw-1:0] a, input int dly, input logic [31:0] exp);
    int n;
    @(posedge clk);
    cs    <= 1'b1;
    we    <= 1'b0;
    adr   <= a;
    sel   <= 4'hf;
    dat_w <= '0;
    wait_response(n);
    if (n >= timeout) begin
      errors++;
      $display("timed out waiting for ack on read of address %h", a);
    end else begin
      check_eq("ack", 1, 32'(ack));
      check_eq("ack latency", 4 * dly + 1, n);
      check_eq("dat_r", exp, dat_r);
    end
    @(posedge clk);
    cs <= 1'b0;  // low for a cycle before the next request
  endtask

  task automatic write_reject(input logic [qaw-1:0] a);
    int             n;
    int             ack_cycles;
    int             err_cycles;
    logic [faw-1:0] adr_before;
    logic [31:0]    dat_before;
    adr_before = fl_adr;
    dat_before = dat_r;
    @(posedge clk);
    cs    <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= $random(seed);
    wait_response(n);
    if (n >= timeout) begin
      errors++;
      $display("timed out waiting for err on write to address %h", a);
    end else begin
      check_eq("err", 1, 32'(err));
      check_eq("err latency", 1, n);
    end
    @(posedge clk);
    cs <= 1'b0;
    we <= 1'b0;
    ack_cycles = 0;
    err_cycles = 0;
    for (int i = 0; i < timeout; i++) begin  // no late ack and no second err
      @(negedge clk);
      if (ack) ack_cycles++;
      if (err) err_cycles++;
    end
    check_eq("ack after write", 0, ack_cycles);
    check_eq("err after write", 0, err_cycles);
    check_eq("fl_adr", 32'(adr_before), 32'(fl_adr));
    check_eq("dat_r", dat_before, dat_r);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    logic [31:0] hold;
    errors         = 0;
    seed           = 1;
    rst            = 1'b1;
    cs             = 1'b0;
    we             = 1'b0;
    adr            = '0;
    sel            = '0;
    dat_w          = '0;
    cfg_we         = 1'b0;
    cfg_dly        = '0;
    cfg_big_endian = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // idle after reset
    repeat (5) @(negedge clk);
    check_eq("dat_r", 0, dat_r);
    check_eq("fl_adr", 0, 32'(fl_adr));
    for (int i = 0; i < 20; i++) addrs[i] = qaw'($random(seed)) & ~qaw'(3);

    // big endian at the reset delay
    for (int i = 0; i < 20; i++) read_word(addrs[i], 4, model_word(addrs[i], 1'b1));
    hold = dat_r;
    repeat (8) @(negedge clk);
    check_eq("dat_r after ack", hold, dat_r);  // sticky while idle

    // little endian
    write_config(4, 1'b0);
    for (int i = 0; i < 20; i++) read_word(addrs[i], 4, model_word(addrs[i], 1'b0));

    // delay programming
    write_config(6, 1'b1);
    for (int i = 0; i < 3; i++) read_word(addrs[i], 6, model_word(addrs[i], 1'b1));
    write_config(2, 1'b1);  // shorter than the part needs
    for (int i = 0; i < 3; i++) read_word(addrs[i], 2, 32'heeeeeeee);
    write_config(0, 1'b1);  // stored as one cycle
    read_word(addrs[3], 1, 32'heeeeeeee);

    // write rejection followed by a normal read
    write_config(4, 1'b1);
    write_reject(addrs[4]);
    read_word(addrs[5], 4, model_word(addrs[5], 1'b1));

    repeat (4) @(negedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
